//--- build.f
+incdir+include
hdl/ooo_pkg.sv
hdl/dispatch_unit.sv
hdl/alu_station.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
test/ooo_core_asserts.sv
test/commit_checker.sv
test/tb_ooo_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP = tb_ooo_core
FILELIST = build.f
OBJ_DIR = obj_dir
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/core_stimulus.txt
# columns: test name, opcode (0 add .. 9 sra), rd (decimal)
# then operand a, operand b and expected result in hex
alu 0 1 00000005 00000007 0000000c
alu 0 2 ffffffff 00000001 00000000
alu 1 3 00000003 00000005 fffffffe
alu 2 4 f0f0f0f0 ff00ff00 f000f000
alu 3 5 f0f0f0f0 0f0f0000 fffff0f0
alu 4 6 aaaaaaaa ffff0000 5555aaaa
alu 5 7 ffffffff 00000001 00000001
alu 6 8 ffffffff 00000001 00000000
shift 7 9 80000081 00000000 80000081
shift 7 10 80000081 00000001 00000102
shift 7 11 80000081 00000011 01020000
shift 7 12 80000081 0000001f 80000000
shift 8 13 80000081 00000000 80000081
shift 8 14 80000081 00000001 40000040
shift 8 15 80000081 00000031 00004000
shift 8 16 80000081 0000001f 00000001
shift 9 17 80000081 00000000 80000081
shift 9 18 80000081 00000001 c0000040
shift 9 19 80000081 00000011 ffffc000
shift 9 20 80000081 0000001f ffffffff
order 7 21 00000001 0000001f 80000000
order 0 22 00000001 00000001 00000002
order 0 23 00000002 00000003 00000005
order 0 24 0000000a 00000014 0000001e
backpressure 0 1 00000001 00000001 00000002
backpressure 8 2 ffff0000 00000010 0000ffff
backpressure 1 3 00000000 00000001 ffffffff
backpressure 7 4 00000003 0000001e c0000000
backpressure 4 5 12345678 ffffffff edcba987
backpressure 9 6 f0000000 00000004 ff000000
backpressure 0 7 7fffffff 00000001 80000000
backpressure 6 8 00000000 00000001 00000001
backpressure 2 9 deadbeef 0000ffff 0000beef
backpressure 3 10 00000100 00000011 00000111

//--- test/tb_ooo_core.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module tb_ooo_core;
	import ooo_pkg::*;

	logic clk = 1'b0;
	logic rst;
	logic in_req;
	alu_op_t in_op;
	logic [`RD_W-1:0] in_rd;
	logic [`XLEN-1:0] in_a;
	logic [`XLEN-1:0] in_b;
	logic in_ack;
	logic commit_req;
	logic [`TAG_W-1:0] commit_tag;
	logic [`RD_W-1:0] commit_rd;
	logic [`XLEN-1:0] commit_value;
	logic commit_ack;

	// drive data per instruction in file order
	logic [3:0] op_q [$];
	logic [`RD_W-1:0] rd_q [$];
	logic [`XLEN-1:0] a_q [$];
	logic [`XLEN-1:0] b_q [$];
	bit slow_q [$];

	int n_lines = 0;
	int limit = 0;
	int cycles = 0;
	int tb_errors = 0;
	logic [15:0] gap_lfsr = 16'd31518;
	logic [15:0] ack_lfsr = 16'd31518;

	always #2 clk = ~clk;

	ooo_core i_dut (
		.clk(clk), .rst(rst), .in_req(in_req), .in_op(in_op), .in_rd(in_rd),
		.in_a(in_a), .in_b(in_b), .in_ack(in_ack), .commit_req(commit_req),
		.commit_tag(commit_tag), .commit_rd(commit_rd), .commit_value(commit_value),
		.commit_ack(commit_ack)
	);

	commit_checker i_checker (
		.clk(clk), .rst(rst), .in_req(in_req), .in_ack(in_ack),
		.commit_req(commit_req), .commit_tag(commit_tag),
		.commit_rd(commit_rd), .commit_value(commit_value)
	);

	bind ooo_core ooo_core_asserts i_asserts (
		.clk(clk), .rst(rst), .in_req(in_req), .in_ack(in_ack), .commit_req(commit_req),
		.commit_ack(commit_ack), .alloc(alloc), .rob_full(rob_full), .taken(taken)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(inout logic [15:0] s, input int n, output int val);
		val = 0;
		for (int k = 0; k < n; k++) begin
			val = {val[30:0], s[15]};
			s = lfsr_next(s);
		end
	endtask

	task automatic read_stimulus();
		int fd;
		int code;
		string line;
		string name;
		logic [3:0] op;
		logic [`RD_W-1:0] rd;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] expected;
		fd = $fopen("test/core_stimulus.txt", "r");
		if (fd == 0) begin
			tb_errors++;
			$display("cannot open test/core_stimulus.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line[0] == "#") begin
					continue;
				end
				code = $sscanf(line, "%s %d %d %h %h %h", name, op, rd, a, b, expected);
				if (code != 6) begin
					tb_errors++;
					$display("stimulus line could not be parsed: %s", line);
				end else begin
					op_q.push_back(op);
					rd_q.push_back(rd);
					a_q.push_back(a);
					b_q.push_back(b);
					slow_q.push_back(name == "backpressure");
					i_checker.expect_commit(name, rd, expected);
					n_lines++;
				end
			end
			$fclose(fd);
		end
	endtask

	// one four-phase transfer after a random idle gap
	task automatic send(input int i);
		int gap;
		draw_bits(gap_lfsr, 2, gap);
		repeat (gap) @(negedge clk);
		in_op = alu_op_t'(op_q[i]);
		in_rd = rd_q[i];
		in_a = a_q[i];
		in_b = b_q[i];
		in_req = 1'b1;
		@(negedge clk);
		while (!in_ack) @(negedge clk);
		in_req = 1'b0;
		@(negedge clk);
		while (in_ack) @(negedge clk);
	endtask

	initial begin
		int total;
		rst = 1'b1;
		in_req = 1'b0;
		in_op = ADD;
		in_rd = '0;
		in_a = '0;
		in_b = '0;
		read_stimulus();
		limit = n_lines * 60 + 100;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		// quiet window before the first request
		repeat (5) @(negedge clk);
		for (int i = 0; i < n_lines; i++) begin
			send(i);
		end
		while (i_checker.commits < n_lines) @(negedge clk);
		// room for any stray extra commit
		repeat (20) @(negedge clk);
		total = tb_errors + i_checker.errors;
		$display("summary: %0d errors, %0d of %0d instructions committed",
			total, i_checker.commits, n_lines);
		if (total == 0 && i_checker.commits == n_lines) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// commit acknowledger that slows down randomly in the backpressure section
	initial begin
		int delay;
		bit slow;
		commit_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (!rst && commit_req) begin
				slow = 1'b0;
				if (slow_q.size() > 0) begin
					slow = slow_q.pop_front();
				end
				delay = 0;
				if (slow) begin
					draw_bits(ack_lfsr, 4, delay);
				end
				repeat (delay) @(negedge clk);
				commit_ack = 1'b1;
				@(negedge clk);
				while (commit_req) @(negedge clk);
				commit_ack = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("timeout after %0d cycles with %0d commits still missing",
				cycles, n_lines - i_checker.commits);
			$display("Checks failed");
			$finish;
		end
	end

endmodule

//--- test/commit_checker.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module commit_checker (
	input logic               clk,
	input logic               rst,
	input logic               in_req,
	input logic               in_ack,
	input logic               commit_req,
	input logic [`TAG_W-1:0]  commit_tag,
	input logic [`RD_W-1:0]   commit_rd,
	input logic [`XLEN-1:0]   commit_value
);

	// expected retirements in program order
	string name_q [$];
	logic [`RD_W-1:0] rd_q [$];
	logic [`XLEN-1:0] value_q [$];

	int errors = 0;
	int commits = 0;
	logic req_seen;
	logic input_seen;
	logic [`TAG_W-1:0] exp_tag;

	task automatic expect_commit(input string name, input logic [`RD_W-1:0] rd,
		input logic [`XLEN-1:0] value);
		name_q.push_back(name);
		rd_q.push_back(rd);
		value_q.push_back(value);
	endtask

	task automatic check_commit();
		string name;
		logic [`RD_W-1:0] rd;
		logic [`XLEN-1:0] value;
		if (name_q.size() == 0) begin
			errors++;
			$display("commit of tag %0d arrived with no instruction left to retire",
				commit_tag);
		end else begin
			name = name_q.pop_front();
			rd = rd_q.pop_front();
			value = value_q.pop_front();
			if (commit_value !== value) begin
				errors++;
				$display("CHECK FAILED %s commit %0d value: expected %h actual %h",
					name, commits, value, commit_value);
			end
			if (commit_rd !== rd) begin
				errors++;
				$display("CHECK FAILED %s commit %0d rd: expected %0d actual %0d",
					name, commits, rd, commit_rd);
			end
			// tags wrap around the rob in program order
			if (commit_tag !== exp_tag) begin
				errors++;
				$display("CHECK FAILED %s commit %0d tag: expected %0d actual %0d",
					name, commits, exp_tag, commit_tag);
			end
		end
		commits++;
		exp_tag = exp_tag + 1'b1;
	endtask

	// one check per rising commit_req sampled mid-cycle
	always @(negedge clk) begin
		if (rst) begin
			req_seen = 1'b0;
			input_seen = 1'b0;
			exp_tag = '0;
		end else begin
			if (in_req) begin
				input_seen = 1'b1;
			end
			// nothing may answer before the first request
			if (!input_seen && (in_ack || commit_req)) begin
				errors++;
				$display("in_ack or commit_req went high after reset before any input");
			end
			if (commit_req && !req_seen) begin
				check_commit();
			end
			req_seen = commit_req;
		end
	end

endmodule

//--- test/ooo_core_asserts.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_core_asserts (
	input logic               clk,
	input logic               rst,
	input logic               in_req,
	input logic               in_ack,
	input logic               commit_req,
	input logic               commit_ack,
	input logic               alloc,
	input logic               rob_full,
	input logic [`NUM_RS-1:0] taken
);

	// ack only answers a request seen on the previous edge
	ack_after_req: assert property (@(posedge clk) disable iff (rst)
		$rose(in_ack) |-> $past(in_req))
		else $error("in_ack rose without a pending in_req");

	commit_req_held: assert property (@(posedge clk) disable iff (rst)
		commit_req && !commit_ack |=> commit_req)
		else $error("commit_req dropped before commit_ack");

	// one write-back grant per cycle
	grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(taken))
		else $error("more than one station granted at once");

	no_alloc_when_full: assert property (@(posedge clk) disable iff (rst) !(alloc && rob_full))
		else $error("rob allocation while full");

endmodule

//--- hdl/ooo_core.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_core (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_req,
	input  ooo_pkg::alu_op_t      in_op,
	input  logic [`RD_W-1:0]      in_rd,
	input  logic [`XLEN-1:0]      in_a,
	input  logic [`XLEN-1:0]      in_b,
	output logic                  in_ack,
	output logic                  commit_req,
	output logic [`TAG_W-1:0]     commit_tag,
	output logic [`RD_W-1:0]      commit_rd,
	output logic [`XLEN-1:0]      commit_value,
	input  logic                  commit_ack
);
	import ooo_pkg::*;

	// dispatch to stations and rob
	logic [`NUM_RS-1:0] issue;
	alu_op_t issue_op;
	logic [`XLEN-1:0] issue_a;
	logic [`XLEN-1:0] issue_b;
	logic [`TAG_W-1:0] issue_tag;
	logic alloc;
	logic [`RD_W-1:0] alloc_rd;
	logic [`TAG_W-1:0] tail_tag;
	logic rob_full;

	// station results toward the rob
	logic [`NUM_RS-1:0] rs_busy;
	logic [`NUM_RS-1:0] rs_done;
	logic [`TAG_W-1:0] rs_tag [`NUM_RS];
	logic [`XLEN-1:0] rs_value [`NUM_RS];
	logic [`NUM_RS-1:0] taken;

	dispatch_unit i_dispatch (
		.clk(clk), .rst(rst),
		.in_req(in_req), .in_op(in_op), .in_rd(in_rd), .in_a(in_a), .in_b(in_b),
		.in_ack(in_ack), .rs_busy(rs_busy), .rob_full(rob_full), .tail_tag(tail_tag),
		.issue(issue), .issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b),
		.issue_tag(issue_tag), .alloc(alloc), .alloc_rd(alloc_rd)
	);

	for (genvar i = 0; i < `NUM_RS; i++) begin : g_rs
		alu_station i_station (
			.clk(clk), .rst(rst),
			.issue(issue[i]), .issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b),
			.issue_tag(issue_tag), .busy(rs_busy[i]), .done(rs_done[i]),
			.done_tag(rs_tag[i]), .done_value(rs_value[i]), .taken(taken[i])
		);
	end

	reorder_buffer i_rob (
		.clk(clk), .rst(rst),
		.alloc(alloc), .alloc_rd(alloc_rd), .tail_tag(tail_tag), .rob_full(rob_full),
		.rs_done(rs_done), .rs_tag(rs_tag), .rs_value(rs_value), .taken(taken),
		.commit_req(commit_req), .commit_tag(commit_tag), .commit_rd(commit_rd),
		.commit_value(commit_value), .commit_ack(commit_ack)
	);

endmodule

//--- hdl/reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module reorder_buffer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  alloc,
	input  logic [`RD_W-1:0]      alloc_rd,
	output logic [`TAG_W-1:0]     tail_tag,
	output logic                  rob_full,
	input  logic [`NUM_RS-1:0]    rs_done,
	input  logic [`TAG_W-1:0]     rs_tag [`NUM_RS],
	input  logic [`XLEN-1:0]      rs_value [`NUM_RS],
	output logic [`NUM_RS-1:0]    taken,
	output logic                  commit_req,
	output logic [`TAG_W-1:0]     commit_tag,
	output logic [`RD_W-1:0]      commit_rd,
	output logic [`XLEN-1:0]      commit_value,
	input  logic                  commit_ack
);
	import ooo_pkg::*;

	commit_state_t state;

	// entry storage
	logic valid_q [`ROB_DEPTH];
	logic ready_q [`ROB_DEPTH];
	logic [`RD_W-1:0] rd_q [`ROB_DEPTH];
	logic [`XLEN-1:0] value_q [`ROB_DEPTH];

	logic [`TAG_W-1:0] head;
	logic [`TAG_W-1:0] tail;
	logic [`TAG_W:0] count;

	logic grant;
	logic [`TAG_W-1:0] grant_tag;
	logic [`XLEN-1:0] grant_value;
	logic head_ok;
	logic pop;

	// one write-back per cycle, lowest finished station wins
	assign taken = rs_done & (~rs_done + 1'b1);
	assign grant = |rs_done;

	always_comb begin
		grant_tag = '0;
		grant_value = '0;
		for (int i = 0; i < `NUM_RS; i++) begin
			if (taken[i]) begin
				grant_tag = rs_tag[i];
				grant_value = rs_value[i];
			end
		end
	end

	assign head_ok = valid_q[head] && ready_q[head];
	assign pop = (state == C_REQ) && commit_ack;

	assign tail_tag = tail;
	assign rob_full = (count == `ROB_DEPTH);
	assign commit_req = (state == C_REQ);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= C_IDLE;
			head <= '0;
			tail <= '0;
			count <= '0;
			for (int i = 0; i < `ROB_DEPTH; i++) begin
				valid_q[i] <= 1'b0;
				ready_q[i] <= 1'b0;
			end
		end else begin
			if (alloc) begin
				valid_q[tail] <= 1'b1;
				ready_q[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			if (grant) begin
				ready_q[grant_tag] <= 1'b1;
			end
			if (pop) begin
				valid_q[head] <= 1'b0;
				head <= head + 1'b1;
			end
			case ({alloc, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			// commit handshake toward the outside
			case (state)
				C_IDLE: begin
					if (head_ok) begin
						state <= C_REQ;
					end
				end
				C_REQ: begin
					if (commit_ack) begin
						state <= C_WAIT_LOW;
					end
				end
				C_WAIT_LOW: begin
					if (!commit_ack) begin
						state <= C_IDLE;
					end
				end
				default: begin
					state <= C_IDLE;
				end
			endcase
		end
	end

	// payload writes and the held commit data
	always_ff @(posedge clk) begin
		if (alloc) begin
			rd_q[tail] <= alloc_rd;
		end
		if (grant) begin
			value_q[grant_tag] <= grant_value;
		end
		if ((state == C_IDLE) && head_ok) begin
			commit_tag <= head;
			commit_rd <= rd_q[head];
			commit_value <= value_q[head];
		end
	end

endmodule

//--- hdl/alu_station.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module alu_station (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  issue,
	input  ooo_pkg::alu_op_t      issue_op,
	input  logic [`XLEN-1:0]      issue_a,
	input  logic [`XLEN-1:0]      issue_b,
	input  logic [`TAG_W-1:0]     issue_tag,
	output logic                  busy,
	output logic                  done,
	output logic [`TAG_W-1:0]     done_tag,
	output logic [`XLEN-1:0]      done_value,
	input  logic                  taken
);
	import ooo_pkg::*;

	rs_state_t state;
	alu_op_t shift_op;
	logic [4:0] shift_left;
	logic [4:0] shamt;
	logic is_shift;
	logic [`XLEN-1:0] quick_result;

	// rv32i takes the shift amount from the low 5 bits of b
	assign shamt = issue_b[4:0];
	assign is_shift = (issue_op == SLL) || (issue_op == SRL) || (issue_op == SRA);

	// single-cycle ops, shifts start from operand a
	always_comb begin
		case (issue_op)
			ADD:     quick_result = issue_a + issue_b;
			SUB:     quick_result = issue_a - issue_b;
			AND:     quick_result = issue_a & issue_b;
			OR:      quick_result = issue_a | issue_b;
			XOR:     quick_result = issue_a ^ issue_b;
			SLT: begin
				quick_result = {{(`XLEN-1){1'b0}}, ($signed(issue_a) < $signed(issue_b))};
			end
			SLTU:    quick_result = {{(`XLEN-1){1'b0}}, (issue_a < issue_b)};
			default: quick_result = issue_a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RS_IDLE;
		end else begin
			case (state)
				RS_IDLE: begin
					if (issue) begin
						// a shift by zero finishes like any other op
						if (is_shift && (shamt != 5'd0)) begin
							state <= RS_EXEC;
						end else begin
							state <= RS_DONE;
						end
					end
				end
				RS_EXEC: begin
					// last bit shifted this cycle
					if (shift_left == 5'd1) begin
						state <= RS_DONE;
					end
				end
				RS_DONE: begin
					// held until the rob grants this station
					if (taken) begin
						state <= RS_IDLE;
					end
				end
				default: begin
					state <= RS_IDLE;
				end
			endcase
		end
	end

	// result register doubles as the shifter
	always_ff @(posedge clk) begin
		if ((state == RS_IDLE) && issue) begin
			done_value <= quick_result;
			done_tag <= issue_tag;
			shift_op <= issue_op;
			shift_left <= shamt;
		end else if (state == RS_EXEC) begin
			shift_left <= shift_left - 5'd1;
			case (shift_op)
				SLL:     done_value <= {done_value[`XLEN-2:0], 1'b0};
				SRL:     done_value <= {1'b0, done_value[`XLEN-1:1]};
				default: done_value <= {done_value[`XLEN-1], done_value[`XLEN-1:1]};
			endcase
		end
	end

	assign busy = (state != RS_IDLE);
	assign done = (state == RS_DONE);

endmodule

//--- hdl/dispatch_unit.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module dispatch_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_req,
	input  ooo_pkg::alu_op_t      in_op,
	input  logic [`RD_W-1:0]      in_rd,
	input  logic [`XLEN-1:0]      in_a,
	input  logic [`XLEN-1:0]      in_b,
	output logic                  in_ack,
	input  logic [`NUM_RS-1:0]    rs_busy,
	input  logic                  rob_full,
	input  logic [`TAG_W-1:0]     tail_tag,
	output logic [`NUM_RS-1:0]    issue,
	output ooo_pkg::alu_op_t      issue_op,
	output logic [`XLEN-1:0]      issue_a,
	output logic [`XLEN-1:0]      issue_b,
	output logic [`TAG_W-1:0]     issue_tag,
	output logic                  alloc,
	output logic [`RD_W-1:0]      alloc_rd
);
	import ooo_pkg::*;

	disp_state_t state;
	logic [`NUM_RS-1:0] pick;
	logic accept;

	// lowest free station as one-hot, zero when all are busy
	assign pick = ~rs_busy & (rs_busy + 1'b1);

	// take the instruction only with a rob slot and a station free
	assign accept = (state == D_IDLE) && in_req && !rob_full && (pick != '0);

	assign in_ack = (state == D_ACK);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= D_IDLE;
			issue <= '0;
			alloc <= 1'b0;
		end else begin
			// issue and alloc are single-cycle pulses
			issue <= '0;
			alloc <= 1'b0;
			case (state)
				D_IDLE: begin
					if (accept) begin
						state <= D_ACK;
						issue <= pick;
						alloc <= 1'b1;
					end
				end
				D_ACK: begin
					// hold ack until the source drops req
					if (!in_req) begin
						state <= D_IDLE;
					end
				end
				default: begin
					state <= D_IDLE;
				end
			endcase
		end
	end

	// operands and tag for the chosen station
	always_ff @(posedge clk) begin
		if (accept) begin
			issue_op <= in_op;
			issue_a <= in_a;
			issue_b <= in_b;
			issue_tag <= tail_tag;
			alloc_rd <= in_rd;
		end
	end

endmodule

//--- hdl/ooo_pkg.sv
package ooo_pkg;

	// alu opcodes, codes match the stimulus file
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		OR   = 4'd3,
		XOR  = 4'd4,
		SLT  = 4'd5,
		SLTU = 4'd6,
		SLL  = 4'd7,
		SRL  = 4'd8,
		SRA  = 4'd9
	} alu_op_t;

	// input handshake phases
	typedef enum logic {
		D_IDLE,
		D_ACK
	} disp_state_t;

	// reservation station phases
	typedef enum logic [1:0] {
		RS_IDLE,
		RS_EXEC,
		RS_DONE
	} rs_state_t;

	// commit handshake phases
	typedef enum logic [1:0] {C_IDLE, C_REQ, C_WAIT_LOW} commit_state_t;

endpackage

//--- include/ooo_params.svh
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// datapath width
`define XLEN 32

// reorder buffer depth and tag width, depth is 2**TAG_W
`define ROB_DEPTH 8
`define TAG_W 3

`define NUM_RS 4
`define RD_W 5

`endif
